/* Bender.yml */
package:
  name: front_end

sources:
  - files:
      - source/frontEndPkg.sv
      - source/pcUnit.sv
      - source/fetchUnit.sv
      - source/instrDecode.sv
      - source/hazardDetect.sv
      - source/wbArbiter.sv
      - source/instrMem.sv
      - source/frontEnd.sv
  - target: test
    files:
      - tb/tbFrontEnd.sv

/* source/fetchUnit.sv */
/*
   Wishbone classic read master for instruction fetch.
   Reads at pc, holds one word with its pc, and starts the next read
   in the cycle the held word is taken.
*/
`timescale 1ns/1ps

module fetchUnit (
   input  logic clk,
   input  logic rstN,
   input  logic [frontEndPkg::instrWidth-1:0] pc,
   input  logic flush,
   input  logic issueTaken,
   input  logic halted,
   input  frontEndPkg::wbRsp_t wbRsp,
   output frontEndPkg::wbReq_t wbReq,
   output logic advance,
   output logic fetchValid,
   output frontEndPkg::instrWord_t fetchWord,
   output logic [frontEndPkg::instrWidth-1:0] fetchPc
);

   typedef enum logic [1:0] {stIdle, stReq, stHold} fetchState_t;

   fetchState_t state;
   logic [frontEndPkg::instrWidth-1:0] reqAdr;
   logic discard;
   logic start;
   logic launch;

   // Fresh read out of idle
   assign start = (state == stIdle) && !halted && !flush;
   // Overlapped read, next word goes out while the held one leaves
   assign launch = (state == stHold) && issueTaken && !flush && !halted;
   assign advance = (state == stHold) && issueTaken;
   assign fetchValid = (state == stHold);

   always_comb begin
      wbReq = '0;
      wbReq.cyc = (state == stReq) || launch;
      wbReq.stb = (state == stReq) || launch;
      wbReq.we = 1'b0;
      // pc still points at the held word here
      wbReq.adr = (state == stHold) ? pc + 1'b1 : reqAdr;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= stIdle;
         discard <= 1'b0;
      end else begin
         unique case (state)
            stIdle: begin
               if (start) begin
                  state <= stReq;
               end
            end
            stReq: begin
               if (wbRsp.ack) begin
                  discard <= 1'b0;
                  // Stale data after a redirect or halt is dropped
                  if (discard || flush || halted) begin
                     state <= stIdle;
                  end else begin
                     state <= stHold;
                  end
               end else if (flush) begin
                  // Finish the bus cycle, throw the data away
                  discard <= 1'b1;
               end
            end
            stHold: begin
               if (flush) begin
                  state <= stIdle;
               end else if (launch) begin
                  state <= stReq;
               end else if (issueTaken) begin
                  state <= stIdle;
               end
            end
            default: begin
               state <= stIdle;
            end
         endcase
      end
   end

   // Address and fetched word
   always_ff @(posedge clk) begin
      if (start) begin
         reqAdr <= pc;
      end else if (launch) begin
         reqAdr <= pc + 1'b1;
      end
      if (state == stReq && wbRsp.ack) begin
         fetchWord <= frontEndPkg::instrWord_t'(wbRsp.dat);
         fetchPc <= reqAdr;
      end
   end

endmodule

/* source/frontEnd.sv */
/*
   Fetch and decode front end top level.
   Loader and fetch share the instruction RAM; issue leaves on a valid/ready port.
*/
`timescale 1ns/1ps

module frontEnd (
   input  logic clk,
   input  logic rstN,
   input  frontEndPkg::wbReq_t loadReq,
   input  logic redirectValid,
   input  logic [frontEndPkg::instrWidth-1:0] redirectTarget,
   input  logic issueReady,
   output frontEndPkg::wbRsp_t loadRsp,
   output logic issueValid,
   output frontEndPkg::issue_t issue,
   output logic halted
);

   logic [frontEndPkg::instrWidth-1:0] pc;
   logic [frontEndPkg::instrWidth-1:0] fetchPc;
   logic advance;
   logic fetchValid;
   logic issueTaken;
   logic haltIssued;
   frontEndPkg::instrWord_t fetchWord;
   frontEndPkg::wbReq_t fetchReq;
   frontEndPkg::wbReq_t memReq;
   frontEndPkg::wbRsp_t fetchRsp;
   frontEndPkg::wbRsp_t memRsp;
   frontEndPkg::ctrl_t candCtrl;
   frontEndPkg::issue_t cand;

   assign cand = '{pc: fetchPc, instr: fetchWord, ctrl: candCtrl};
   // Freeze only on an accepted halt
   assign haltIssued = issueValid && issueReady && issue.ctrl.halt;

   pcUnit i_pcUnit (
      .clk(clk), .rstN(rstN), .advance(advance),
      .redirectValid(redirectValid), .redirectTarget(redirectTarget),
      .halt(haltIssued), .pc(pc), .halted(halted)
   );

   fetchUnit i_fetchUnit (
      .clk(clk), .rstN(rstN), .pc(pc), .flush(redirectValid),
      .issueTaken(issueTaken), .halted(halted), .wbRsp(fetchRsp),
      .wbReq(fetchReq), .advance(advance), .fetchValid(fetchValid),
      .fetchWord(fetchWord), .fetchPc(fetchPc)
   );

   instrDecode i_instrDecode (.instr(fetchWord), .ctrl(candCtrl));

   hazardDetect i_hazardDetect (
      .clk(clk), .rstN(rstN), .fetchValid(fetchValid), .cand(cand),
      .issueReady(issueReady), .issueTaken(issueTaken),
      .issueValid(issueValid), .issue(issue)
   );

   wbArbiter i_wbArbiter (
      .clk(clk), .rstN(rstN), .loadReq(loadReq), .fetchReq(fetchReq),
      .memRsp(memRsp), .loadRsp(loadRsp), .fetchRsp(fetchRsp), .memReq(memReq)
   );

   instrMem i_instrMem (.clk(clk), .rstN(rstN), .req(memReq), .rsp(memRsp));

endmodule

/* source/frontEndPkg.sv */
/*
   Shared sizes, opcodes and bus types for the processor front end.
   Every RTL file refers to these by scoped name.
*/
package frontEndPkg;

   // Word width, also the address width (word addressed)
   localparam int instrWidth = 16;
   localparam int memDepth = 256;
   localparam int regAddrWidth = 3;
   // Jal writes its return address here
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;
   // Bubble word, nop opcode and zero fields
   localparam logic [instrWidth-1:0] nopWord = 16'h0800;

   // Opcodes in bits 15:11
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opNop = 5'b00001;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opLoad = 5'b10001;
   localparam logic [4:0] opStore = 5'b10000;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opJal = 5'b00110;
   localparam logic [4:0] opAlu = 5'b11011;

   // One word, two field layouts
   typedef union packed {
      struct packed {
         logic [4:0] opcode;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rt;
         logic [regAddrWidth-1:0] rd;
         logic [1:0] func;
      } rFmt;
      struct packed {
         logic [4:0] opcode;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rd;
         logic [4:0] imm;
      } iFmt;
   } instrWord_t;

   typedef struct packed {
      logic regWrite;
      logic memEnable;
      logic memWrite;
      logic branch;
      logic jump;
      logic link;
      logic halt;
      logic ctrlErr;
      logic usesRs;
      logic usesRt;
      logic [regAddrWidth-1:0] destReg;
   } ctrl_t;

   // Downstream payload
   typedef struct packed {
      logic [instrWidth-1:0] pc;
      instrWord_t instr;
      ctrl_t ctrl;
   } issue_t;

   // Wishbone classic, master to slave
   typedef struct packed {
      logic cyc;
      logic stb;
      logic we;
      logic [instrWidth-1:0] adr;
      logic [instrWidth-1:0] dat;
   } wbReq_t;

   // Wishbone classic, slave to master
   typedef struct packed {
      logic ack;
      logic [instrWidth-1:0] dat;
   } wbRsp_t;

endpackage

/* source/hazardDetect.sv */
/*
   Issue stage with a two-slot window of pending destination registers.
   A source hit on the window issues a nop bubble and keeps the word.
*/
`timescale 1ns/1ps

module hazardDetect (
   input  logic clk,
   input  logic rstN,
   input  logic fetchValid,
   input  frontEndPkg::issue_t cand,
   input  logic issueReady,
   output logic issueTaken,
   output logic issueValid,
   output frontEndPkg::issue_t issue
);

   // Slot 0 is the newest issue
   logic [1:0] slotValid;
   logic [1:0][frontEndPkg::regAddrWidth-1:0] slotReg;
   logic rsHit;
   logic rtHit;
   logic hazard;
   logic accept;

   assign rsHit = cand.ctrl.usesRs &&
      ((slotValid[0] && slotReg[0] == cand.instr.rFmt.rs) ||
       (slotValid[1] && slotReg[1] == cand.instr.rFmt.rs));
   assign rtHit = cand.ctrl.usesRt &&
      ((slotValid[0] && slotReg[0] == cand.instr.rFmt.rt) ||
       (slotValid[1] && slotReg[1] == cand.instr.rFmt.rt));
   assign hazard = rsHit || rtHit;

   assign issueValid = fetchValid;
   assign accept = issueValid && issueReady;
   // Only a real issue frees the held word
   assign issueTaken = accept && !hazard;

   always_comb begin
      issue = cand;
      if (hazard) begin
         // Bubble keeps the held pc
         issue.instr = frontEndPkg::instrWord_t'(frontEndPkg::nopWord);
         issue.ctrl = '0;
      end
   end

   // Bubbles shift the window too
   always_ff @(posedge clk) begin
      if (!rstN) begin
         slotValid <= '0;
         slotReg <= '0;
      end else if (accept) begin
         slotValid <= {slotValid[0], issue.ctrl.regWrite};
         slotReg <= {slotReg[0], issue.ctrl.destReg};
      end
   end

endmodule

/* source/instrDecode.sv */
/*
   Combinational decode of one instruction word into control fields.
   Picks the destination register from the matching format view.
*/
`timescale 1ns/1ps

module instrDecode (
   input  frontEndPkg::instrWord_t instr,
   output frontEndPkg::ctrl_t ctrl
);

   always_comb begin
      ctrl = '0;
      unique case (instr.rFmt.opcode)
         frontEndPkg::opHalt: begin
            ctrl.halt = 1'b1;
         end
         frontEndPkg::opNop: begin
            // Nothing to do
            ctrl = '0;
         end
         frontEndPkg::opAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.usesRs = 1'b1;
            ctrl.destReg = instr.iFmt.rd;
         end
         frontEndPkg::opLoad: begin
            ctrl.regWrite = 1'b1;
            ctrl.memEnable = 1'b1;
            ctrl.usesRs = 1'b1;
            ctrl.destReg = instr.iFmt.rd;
         end
         frontEndPkg::opStore: begin
            // Base in rs, store data in bits 7:5
            ctrl.memEnable = 1'b1;
            ctrl.memWrite = 1'b1;
            ctrl.usesRs = 1'b1;
            ctrl.usesRt = 1'b1;
         end
         frontEndPkg::opBeqz: begin
            ctrl.branch = 1'b1;
            ctrl.usesRs = 1'b1;
         end
         frontEndPkg::opJal: begin
            // Return address goes to r7
            ctrl.jump = 1'b1;
            ctrl.link = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.destReg = frontEndPkg::linkReg;
         end
         frontEndPkg::opAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.usesRs = 1'b1;
            ctrl.usesRt = 1'b1;
            ctrl.destReg = instr.rFmt.rd;
         end
         default: begin
            // Illegal opcode, otherwise behaves as nop
            ctrl.ctrlErr = 1'b1;
         end
      endcase
   end

endmodule

/* source/instrMem.sv */
/*
   Instruction RAM as a Wishbone classic slave.
   Read data and ack are registered, so a transfer takes two cycles.
*/
`timescale 1ns/1ps

module instrMem (
   input  logic clk,
   input  logic rstN,
   input  frontEndPkg::wbReq_t req,
   output frontEndPkg::wbRsp_t rsp
);

   logic [frontEndPkg::instrWidth-1:0] ram [frontEndPkg::memDepth];
   logic [frontEndPkg::instrWidth-1:0] datQ;
   logic ackQ;
   logic sample;

   // No new sample in the ack cycle
   assign sample = req.cyc && req.stb && !ackQ;
   assign rsp = '{ack: ackQ, dat: datQ};

   always_ff @(posedge clk) begin
      if (!rstN) begin
         ackQ <= 1'b0;
      end else begin
         ackQ <= sample;
      end
   end

   // Low address bits index the array
   always_ff @(posedge clk) begin
      if (sample) begin
         if (req.we) begin
            ram[req.adr[$clog2(frontEndPkg::memDepth)-1:0]] <= req.dat;
         end
         datQ <= ram[req.adr[$clog2(frontEndPkg::memDepth)-1:0]];
      end
   end

endmodule

/* source/pcUnit.sv */
/*
   Program counter with redirect, sequential advance and halt freeze.
   Advance comes from the fetch unit once a word is accepted.
*/
`timescale 1ns/1ps

module pcUnit (
   input  logic clk,
   input  logic rstN,
   input  logic advance,
   input  logic redirectValid,
   input  logic [frontEndPkg::instrWidth-1:0] redirectTarget,
   input  logic halt,
   output logic [frontEndPkg::instrWidth-1:0] pc,
   output logic halted
);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
         halted <= 1'b0;
      end else if (!halted) begin
         // Redirect wins over advance
         if (redirectValid) begin
            pc <= redirectTarget;
         end else if (advance && !halt) begin
            // Word addressing, step of one
            pc <= pc + 1'b1;
         end
         // Sticky until reset
         if (halt) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

/* source/wbArbiter.sv */
/*
   Fixed-priority Wishbone classic arbiter, loader ahead of fetch.
   Grant is taken only with no cycle open and held until the ack.
*/
`timescale 1ns/1ps

module wbArbiter (
   input  logic clk,
   input  logic rstN,
   input  frontEndPkg::wbReq_t loadReq,
   input  frontEndPkg::wbReq_t fetchReq,
   input  frontEndPkg::wbRsp_t memRsp,
   output frontEndPkg::wbRsp_t loadRsp,
   output frontEndPkg::wbRsp_t fetchRsp,
   output frontEndPkg::wbReq_t memReq
);

   logic busy;
   logic ownerLoad;
   logic selLoad;

   // Free bus, loader wins a tie
   assign selLoad = busy ? ownerLoad : loadReq.cyc;
   assign memReq = selLoad ? loadReq : fetchReq;

   // Ack goes back to the owner only
   always_comb begin
      loadRsp.ack = memRsp.ack && selLoad;
      loadRsp.dat = memRsp.dat;
      fetchRsp.ack = memRsp.ack && !selLoad;
      fetchRsp.dat = memRsp.dat;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         busy <= 1'b0;
         ownerLoad <= 1'b0;
      end else if (!busy) begin
         if (memReq.cyc) begin
            busy <= 1'b1;
            ownerLoad <= selLoad;
         end
      end else if (memRsp.ack) begin
         // Reopen arbitration next cycle
         busy <= 1'b0;
      end
   end

endmodule

/* tb.f */
source/frontEndPkg.sv
source/pcUnit.sv
source/fetchUnit.sv
source/instrDecode.sv
source/hazardDetect.sv
source/wbArbiter.sv
source/instrMem.sv
source/frontEnd.sv
tb/tbFrontEnd.sv

/* tb/tbFrontEnd.sv */
/*
   Testbench for the front end. Loads a program through the loader port,
   then checks issue order, decode, hazard bubbles, stalls, redirect and halt
   against a table of words with expected destinations and bubble counts.
*/
`timescale 1ns/1ps

module tbFrontEnd;

   localparam int numEntries = 16;
   // Second pass starts here
   localparam int redirectIdx = 3;
   localparam int cycleLimit = 40 * numEntries + 200;

   typedef struct packed {
      logic [15:0] word;
      logic [2:0] dest;
      logic [1:0] bubbles;
   } progEntry_t;

   logic clk = 1'b0;
   logic rstN;
   logic redirectValid;
   logic [15:0] redirectTarget;
   logic issueReady;
   logic issueValid;
   logic halted;
   frontEndPkg::wbReq_t loadReq;
   frontEndPkg::wbRsp_t loadRsp;
   frontEndPkg::issue_t issue;
   progEntry_t progTable [numEntries];
   int errorCount = 0;
   int checkCount = 0;
   int cycleCount = 0;

   frontEnd i_dut (
      .clk(clk), .rstN(rstN), .loadReq(loadReq), .redirectValid(redirectValid),
      .redirectTarget(redirectTarget), .issueReady(issueReady), .loadRsp(loadRsp),
      .issueValid(issueValid), .issue(issue), .halted(halted)
   );

   always #5 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         $display("Checks: %0d, errors: %0d", checkCount, errorCount);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      end
   endtask

   function automatic logic [15:0] encodeI(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] encodeR(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] func);
      return {op, rs, rt, rd, func};
   endfunction

   // Reference decode, flags and destination per opcode
   function automatic frontEndPkg::ctrl_t expectedCtrl(input logic [15:0] word);
      frontEndPkg::ctrl_t c;
      c = '0;
      case (word[15:11])
         frontEndPkg::opHalt: c.halt = 1'b1;
         frontEndPkg::opNop: c = '0;
         frontEndPkg::opAddi: begin
            {c.regWrite, c.usesRs} = 2'b11;
            // I-format rd
            c.destReg = word[7:5];
         end
         frontEndPkg::opLoad: begin
            {c.regWrite, c.memEnable, c.usesRs} = 3'b111;
            c.destReg = word[7:5];
         end
         frontEndPkg::opStore: {c.memEnable, c.memWrite, c.usesRs, c.usesRt} = 4'hf;
         frontEndPkg::opBeqz: {c.branch, c.usesRs} = 2'b11;
         frontEndPkg::opJal: begin
            {c.jump, c.link, c.regWrite} = 3'b111;
            // Link register
            c.destReg = 3'd7;
         end
         frontEndPkg::opAlu: begin
            {c.regWrite, c.usesRs, c.usesRt} = 3'b111;
            // R-format rd
            c.destReg = word[4:2];
         end
         default: c.ctrlErr = 1'b1;
      endcase
      return c;
   endfunction

   // Word, destination, bubbles before it
   task automatic fillTable();
      progTable[0] = '{encodeI(frontEndPkg::opAddi, 0, 1, 3), 3'd1, 2'd0};
      progTable[1] = '{encodeI(frontEndPkg::opAddi, 0, 2, 5), 3'd2, 2'd0};
      // Needs r2 from the previous issue
      progTable[2] = '{encodeR(frontEndPkg::opAlu, 1, 2, 3, 0), 3'd3, 2'd2};
      progTable[3] = '{encodeI(frontEndPkg::opAddi, 5, 4, 1), 3'd4, 2'd0};
      // r3 two issues back
      progTable[4] = '{encodeR(frontEndPkg::opStore, 3, 6, 0, 0), 3'd0, 2'd1};
      progTable[5] = '{encodeI(frontEndPkg::opLoad, 0, 5, 2), 3'd5, 2'd0};
      progTable[6] = '{encodeI(frontEndPkg::opBeqz, 5, 0, 4), 3'd0, 2'd2};
      progTable[7] = '{encodeI(frontEndPkg::opJal, 0, 0, 10), 3'd7, 2'd0};
      // Reads the link register
      progTable[8] = '{encodeR(frontEndPkg::opAlu, 7, 1, 1, 1), 3'd1, 2'd2};
      // Illegal opcode 11111
      progTable[9] = '{16'hf800, 3'd0, 2'd0};
      progTable[10] = '{frontEndPkg::nopWord, 3'd0, 2'd0};
      progTable[11] = '{encodeI(frontEndPkg::opAddi, 1, 2, 1), 3'd2, 2'd0};
      progTable[12] = '{encodeR(frontEndPkg::opAlu, 2, 4, 6, 2), 3'd6, 2'd2};
      progTable[13] = '{encodeI(frontEndPkg::opAddi, 0, 3, 7), 3'd3, 2'd0};
      progTable[14] = '{encodeR(frontEndPkg::opStore, 0, 6, 0, 0), 3'd0, 2'd1};
      progTable[15] = '{16'h0000, 3'd0, 2'd0};
   endtask

   // Wishbone classic write, returns on the falling edge after the ack cycle
   task automatic writeWord(input logic [15:0] adr, input logic [15:0] dat);
      loadReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
      do @(negedge clk); while (!loadRsp.ack);
      @(negedge clk);
   endtask

   // Wishbone classic read, data taken in the ack cycle
   task automatic readWord(input logic [15:0] adr, output logic [15:0] dat);
      loadReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0};
      do @(negedge clk); while (!loadRsp.ack);
      dat = loadRsp.dat;
      @(negedge clk);
   endtask

   task automatic redirectTo(input logic [15:0] target);
      @(negedge clk);
      redirectValid = 1'b1;
      redirectTarget = target;
      @(negedge clk);
      redirectValid = 1'b0;
   endtask

   task automatic applyReset();
      @(negedge clk);
      rstN = 1'b0;
      issueReady = 1'b0;
      repeat (2) @(negedge clk);
      rstN = 1'b1;
      checkEq(halted, 0, "halted cleared by reset");
      checkEq(issueValid, 0, "no issue out of reset");
   endtask

   // Random stalls, every accepted issue is matched against the table
   task automatic runProgram(input int startIdx);
      int idx;
      int bubbles;
      bit done;
      bit pending;
      bit ready;
      frontEndPkg::issue_t heldIssue;
      idx = startIdx;
      bubbles = 0;
      done = 1'b0;
      pending = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (pending) begin
            checkEq(issueValid, 1, "valid held under stall");
            checkEq(issue, heldIssue, "payload held under stall");
         end
         ready = ($urandom % 4) != 0;
         issueReady = ready;
         pending = issueValid && !ready;
         heldIssue = issue;
         if (issueValid && ready) begin
            if (issue.instr == progTable[idx].word) begin
               checkEq(issue.pc, idx, "issued pc");
               // Window before the redirect target is not the table's
               if (startIdx == 0 || idx >= startIdx + 2) begin
                  checkEq(bubbles, progTable[idx].bubbles, "bubble count");
               end
               checkEq(issue.ctrl.destReg, progTable[idx].dest, "destination register");
               checkEq(issue.ctrl, expectedCtrl(progTable[idx].word), "ctrl fields");
               done = issue.ctrl.halt || (idx == numEntries - 1);
               idx++;
               bubbles = 0;
            end else if (issue.instr == frontEndPkg::nopWord) begin
               checkEq(issue.pc, idx, "bubble pc");
               checkEq(issue.ctrl, 0, "bubble ctrl");
               bubbles++;
            end else begin
               checkEq(issue.instr, progTable[idx].word, "issued word");
               done = (idx == numEntries - 1);
               idx++;
               bubbles = 0;
            end
         end
      end
   endtask

   task automatic checkHalt();
      repeat (10) begin
         @(negedge clk);
         issueReady = 1'b1;
         checkEq(halted, 1, "halted after halt issue");
         if (issueValid && issue.pc > numEntries - 1) begin
            checkEq(issue.pc, numEntries - 1, "issue past halt");
         end
      end
   endtask

   initial begin
      logic [15:0] readBack;
      void'($urandom(32'h30a5e12e));
      rstN = 1'b0;
      loadReq = '0;
      redirectValid = 1'b0;
      redirectTarget = '0;
      issueReady = 1'b0;
      fillTable();
      repeat (2) @(negedge clk);
      rstN = 1'b1;
      // Program load, downstream held off
      for (int i = 0; i < numEntries; i++) begin
         writeWord(i, progTable[i].word);
      end
      // Read back through the same port
      for (int i = 0; i < numEntries; i++) begin
         readWord(i, readBack);
         checkEq(readBack, progTable[i].word, "loader read back");
      end
      loadReq = '0;
      // Drop whatever fetch picked up during the load
      redirectTo(16'd0);
      runProgram(0);
      checkHalt();
      // Memory keeps its contents over reset
      applyReset();
      redirectTo(redirectIdx);
      runProgram(redirectIdx);
      checkHalt();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
